// ==== bench/axil_host_tasks.svh ====
// --------------------
// AXI4-Lite host tasks, reference model and directed tests
// Included inside tb_shared_ram and uses its bus signals
// Reads only entries and slices that were written first
// --------------------
`ifndef AXIL_HOST_TASKS_SVH
`define AXIL_HOST_TASKS_SVH

// Stop at the first wrong value
task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                        input string what);
  if (actual !== expected) begin
    $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
    $display("sim failed");
    $fatal(1, "value mismatch");
  end
endtask

// Bits 10..5 entry, bits 4..3 slice, low bits zero
function automatic logic [axil_pkg::AXIL_AW-1:0] bus_addr(input int entry, input int slice);
  logic [axil_pkg::AXIL_AW-1:0] a;
  a = '0;
  a[axil_pkg::ADDR_ENTRY_LSB +: sram_geom_pkg::ENTRY_AW] = entry[sram_geom_pkg::ENTRY_AW-1:0];
  a[axil_pkg::ADDR_SLICE_LSB +: sram_geom_pkg::SLICE_IW] = slice[sram_geom_pkg::SLICE_IW-1:0];
  return a;
endfunction

// Slices 0 and 1 hold 48 bits, slice 2 only two
function automatic logic [63:0] slice_mask(input int slice);
  if (slice == 2) begin
    return (64'd1 << sram_geom_pkg::SLICE_HI_W) - 64'd1;
  end else begin
    return (64'd1 << sram_geom_pkg::SLICE_LO_W) - 64'd1;
  end
endfunction

function automatic logic [63:0] rand_word();
  return {$urandom, $urandom};
endfunction

// AW and W raised together, B taken with bready high
task automatic axil_write(input int p, input int entry, input int slice,
                          input logic [63:0] data, output logic [1:0] resp);
  @(posedge CLK);
  awvalid[p] <= 1'b1;
  awaddr[p]  <= bus_addr(entry, slice);
  wvalid[p]  <= 1'b1;
  wdata[p]   <= data;
  wstrb[p]   <= 8'hff;
  @(negedge CLK);
  while (!awready[p]) begin
    @(negedge CLK);
  end
  // Handshake on this edge
  @(posedge CLK);
  awvalid[p] <= 1'b0;
  wvalid[p]  <= 1'b0;
  @(negedge CLK);
  while (!bvalid[p]) begin
    @(negedge CLK);
  end
  resp = bresp[p];
  @(posedge CLK);
endtask

// AR channel only
task automatic send_ar(input int p, input int entry, input int slice);
  @(posedge CLK);
  arvalid[p] <= 1'b1;
  araddr[p]  <= bus_addr(entry, slice);
  @(negedge CLK);
  while (!arready[p]) begin
    @(negedge CLK);
  end
  @(posedge CLK);
  arvalid[p] <= 1'b0;
endtask

// R channel, completes on the edge after rvalid is seen
task automatic get_r(input int p, output logic [63:0] data, output logic [1:0] resp);
  @(negedge CLK);
  while (!rvalid[p]) begin
    @(negedge CLK);
  end
  data = rdata[p];
  resp = rresp[p];
  @(posedge CLK);
endtask

task automatic axil_read(input int p, input int entry, input int slice,
                         output logic [63:0] data, output logic [1:0] resp);
  send_ar(p, entry, slice);
  get_r(p, data, resp);
endtask

// Write and record the expected slice contents
task automatic model_write(input int p, input int entry, input int slice,
                           input logic [63:0] data);
  logic [1:0] resp;
  axil_write(p, entry, slice, data, resp);
  check_eq(resp, axil_pkg::RESP_OKAY, $sformatf("bresp port %0d", p));
  model[entry][slice]   = data & slice_mask(slice);
  written[entry][slice] = 1'b1;
endtask

task automatic check_read(input int p, input int entry, input int slice);
  logic [63:0] data;
  logic [1:0]  resp;
  axil_read(p, entry, slice, data, resp);
  check_eq(resp, axil_pkg::RESP_OKAY, $sformatf("rresp port %0d", p));
  check_eq(data, model[entry][slice],
           $sformatf("rdata port %0d entry %0d slice %0d", p, entry, slice));
endtask

// Every slice written so far, through one port
task automatic check_all(input int p);
  for (int e = 0; e < sram_geom_pkg::DEPTH; e++) begin
    for (int s = 0; s < sram_geom_pkg::SLICE_CNT; s++) begin
      if (written[e][s]) begin
        check_read(p, e, s);
      end
    end
  end
endtask

task automatic test_reset_round_trip();
  int entries [4];
  entries = '{0, 9, 33, 63};
  @(negedge CLK);
  check_eq({awready, wready, arready, bvalid, rvalid}, '0, "ready and valid after reset");
  // Upper bits of random words land above slice widths
  foreach (entries[i]) begin
    for (int s = 0; s < sram_geom_pkg::SLICE_CNT; s++) begin
      model_write(0, entries[i], s, rand_word());
    end
  end
  check_all(0);
endtask

task automatic test_slice_independence();
  model_write(0, 9, 1, rand_word());
  check_all(0);
endtask

task automatic test_sharing();
  model_write(1, 40, 0, rand_word());
  check_read(0, 40, 0);
  model_write(0, 41, 2, rand_word());
  check_read(1, 41, 2);
endtask

// Same start cycle on both hosts, entries in separate halves
task automatic test_concurrency();
  int ea;
  int eb;
  int sa;
  int sb;
  for (int n = 0; n < 3; n++) begin
    ea = $urandom % 32;
    eb = 32 + $urandom % 32;
    sa = $urandom % 3;
    sb = $urandom % 3;
    fork
      model_write(0, ea, sa, rand_word());
      model_write(1, eb, sb, rand_word());
    join
    fork
      check_read(0, ea, sa);
      check_read(1, eb, sb);
    join
  end
endtask

task automatic test_backpressure();
  logic [63:0] held;
  logic [63:0] data;
  logic [1:0]  resp;
  @(posedge CLK);
  rready[0] <= 1'b0;
  send_ar(0, 40, 0);
  @(negedge CLK);
  while (!rvalid[0]) begin
    @(negedge CLK);
  end
  held = rdata[0];
  check_eq(held, model[40][0], "rdata before back-pressure");
  // New read waits behind the stalled response
  @(posedge CLK);
  arvalid[0] <= 1'b1;
  araddr[0]  <= bus_addr(41, 2);
  for (int i = 0; i < 10; i++) begin
    @(negedge CLK);
    check_eq(rvalid[0], 1'b1, "rvalid under back-pressure");
    check_eq(rdata[0], held, "rdata under back-pressure");
    check_eq(arready[0], 1'b0, "arready under back-pressure");
  end
  @(posedge CLK);
  rready[0] <= 1'b1;
  @(negedge CLK);
  while (!arready[0]) begin
    @(negedge CLK);
  end
  @(posedge CLK);
  arvalid[0] <= 1'b0;
  get_r(0, data, resp);
  check_eq(resp, axil_pkg::RESP_OKAY, "rresp after back-pressure");
  check_eq(data, model[41][2], "rdata after back-pressure");
endtask

task automatic test_bad_slice();
  logic [63:0] data;
  logic [1:0]  resp;
  axil_write(0, 9, 3, rand_word(), resp);
  check_eq(resp, axil_pkg::RESP_SLVERR, "bresp for slice 3");
  axil_read(1, 9, 3, data, resp);
  check_eq(resp, axil_pkg::RESP_SLVERR, "rresp for slice 3");
  check_eq(data, '0, "rdata for slice 3");
  check_read(0, 9, 1);
  check_read(1, 40, 0);
endtask

`endif

// ==== bench/tb_shared_ram.sv ====
// --------------------
// Directed testbench for the shared slice RAM
// Stops at the first error, watchdog bounds the run
// --------------------
`timescale 1ns/100ps

module tb_shared_ram;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  // Bus operations issued by all tests, rounded up
  localparam int BUS_OPS = 60;
  // 50 cycles per operation plus reset and the 10-cycle stall
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + BUS_OPS * 50 + 10;

  logic CLK = 1'b0;
  logic rst;

  // Host side, index 0 is h0 and index 1 is h1
  logic [1:0]                             awvalid;
  logic [1:0][axil_pkg::AXIL_AW-1:0]      awaddr;
  logic [1:0]                             wvalid;
  logic [1:0][axil_pkg::AXIL_DW-1:0]      wdata;
  logic [1:0][axil_pkg::AXIL_DW/8-1:0]    wstrb;
  logic [1:0]                             bready;
  logic [1:0]                             arvalid;
  logic [1:0][axil_pkg::AXIL_AW-1:0]      araddr;
  logic [1:0]                             rready;

  // DUT outputs
  wire  [1:0]                             awready;
  wire  [1:0]                             wready;
  wire  [1:0]                             bvalid;
  wire  [1:0][1:0]                        bresp;
  wire  [1:0]                             arready;
  wire  [1:0]                             rvalid;
  wire  [1:0][axil_pkg::AXIL_DW-1:0]      rdata;
  wire  [1:0][1:0]                        rresp;

  // Expected slice contents, zero above the slice width
  logic [63:0] model [sram_geom_pkg::DEPTH][sram_geom_pkg::SLICE_CNT];
  bit          written [sram_geom_pkg::DEPTH][sram_geom_pkg::SLICE_CNT];

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  shared_slice_ram_top #(.ENTRY_AW(sram_geom_pkg::ENTRY_AW)) dut0 (
    .CLK        (CLK),
    .rst        (rst),
    .h0_awvalid (awvalid[0]),
    .h0_awready (awready[0]),
    .h0_awaddr  (awaddr[0]),
    .h0_wvalid  (wvalid[0]),
    .h0_wready  (wready[0]),
    .h0_wdata   (wdata[0]),
    .h0_wstrb   (wstrb[0]),
    .h0_bvalid  (bvalid[0]),
    .h0_bready  (bready[0]),
    .h0_bresp   (bresp[0]),
    .h0_arvalid (arvalid[0]),
    .h0_arready (arready[0]),
    .h0_araddr  (araddr[0]),
    .h0_rvalid  (rvalid[0]),
    .h0_rready  (rready[0]),
    .h0_rdata   (rdata[0]),
    .h0_rresp   (rresp[0]),
    .h1_awvalid (awvalid[1]),
    .h1_awready (awready[1]),
    .h1_awaddr  (awaddr[1]),
    .h1_wvalid  (wvalid[1]),
    .h1_wready  (wready[1]),
    .h1_wdata   (wdata[1]),
    .h1_wstrb   (wstrb[1]),
    .h1_bvalid  (bvalid[1]),
    .h1_bready  (bready[1]),
    .h1_bresp   (bresp[1]),
    .h1_arvalid (arvalid[1]),
    .h1_arready (arready[1]),
    .h1_araddr  (araddr[1]),
    .h1_rvalid  (rvalid[1]),
    .h1_rready  (rready[1]),
    .h1_rdata   (rdata[1]),
    .h1_rresp   (rresp[1])
  );

  `include "axil_host_tasks.svh"

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(98));
    // All inputs idle, response ready held high by default
    rst     <= 1'b1;
    awvalid <= '0;
    awaddr  <= '0;
    wvalid  <= '0;
    wdata   <= '0;
    wstrb   <= '0;
    bready  <= '1;
    arvalid <= '0;
    araddr  <= '0;
    rready  <= '1;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst <= 1'b0;

    test_reset_round_trip();
    test_slice_independence();
    test_sharing();
    test_concurrency();
    test_backpressure();
    test_bad_slice();

    $display("sim passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+bench
source/sram_geom_pkg.sv
source/axil_pkg.sv
source/fpga_ram.sv
source/spsram_64x98.sv
source/axil_slice_port.sv
source/ram_arbiter.sv
source/shared_slice_ram_top.sv
bench/tb_shared_ram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_shared_ram -o tb_shared_ram_sim

# The log decides the result, not the exit status of the run
./obj_dir/tb_shared_ram_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
echo "Simulation finished cleanly"

// ==== source/axil_pkg.sv ====
// --------------------
// AXI4-Lite bus constants
// Address bits 2..0 are ignored
// --------------------
package axil_pkg;

  localparam int AXIL_AW = 11;
  localparam int AXIL_DW = 64;

  // Response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Bits 4..3 select the slice
  localparam int ADDR_SLICE_LSB = 3;

  // Bits 10..5 select the entry
  localparam int ADDR_ENTRY_LSB = 5;

endpackage

// ==== source/axil_slice_port.sv ====
// --------------------
// AXI4-Lite slave, one transaction at a time
// WSTRB ignored, a write replaces the whole slice
// Slice index 3 answers SLVERR
// --------------------
`timescale 1ns/100ps

module axil_slice_port #(
  parameter int ENTRY_AW = 6
) (
  input  logic                                 CLK,
  input  logic                                 rst,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [axil_pkg::AXIL_AW-1:0]         awaddr,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [axil_pkg::AXIL_DW-1:0]         wdata,
  input  logic [axil_pkg::AXIL_DW/8-1:0]       wstrb,
  output logic                                 bvalid,
  input  logic                                 bready,
  output logic [1:0]                           bresp,
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [axil_pkg::AXIL_AW-1:0]         araddr,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [axil_pkg::AXIL_DW-1:0]         rdata,
  output logic [1:0]                           rresp,
  output logic                                 req,
  output logic                                 req_we,
  output logic [ENTRY_AW-1:0]                  req_entry,
  output logic [sram_geom_pkg::SLICE_IW-1:0]   req_slice,
  output logic [sram_geom_pkg::SLICE_LO_W-1:0] req_wdata,
  input  logic                                 gnt,
  input  logic                                 rsp_valid,
  input  logic [axil_pkg::AXIL_DW-1:0]         rsp_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_RESP
  } state_t;

  state_t                            state;
  logic                              is_wr;
  logic                              bad;
  logic [1:0]                        resp;
  logic                              wr_acc;
  logic                              rd_acc;
  logic                              done;
  logic [axil_pkg::AXIL_AW-1:0]      acc_addr;
  logic [sram_geom_pkg::SLICE_IW-1:0] acc_slice;

  // Write wins when both channels are valid
  assign wr_acc = (state == ST_IDLE) && awvalid && wvalid;
  assign rd_acc = (state == ST_IDLE) && arvalid && !awvalid && !wvalid;

  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;

  // Address decode of the accepted channel
  assign acc_addr  = wr_acc ? awaddr : araddr;
  assign acc_slice = acc_addr[axil_pkg::ADDR_SLICE_LSB +: sram_geom_pkg::SLICE_IW];

  // Response ready, bad slice skips the array
  assign done = (state == ST_WAIT) && (bad || rsp_valid);

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (wr_acc || rd_acc) begin
            state <= (acc_slice >= sram_geom_pkg::SLICE_CNT) ? ST_WAIT : ST_REQ;
          end
        end
        ST_REQ: begin
          if (gnt) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (done) begin
            state <= ST_RESP;
          end
        end
        default: begin
          // Held until the host takes the response
          if ((is_wr && bready) || (!is_wr && rready)) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Request payload captured on acceptance
  always_ff @(posedge CLK) begin
    if (wr_acc || rd_acc) begin
      is_wr     <= wr_acc;
      bad       <= (acc_slice >= sram_geom_pkg::SLICE_CNT);
      req_entry <= acc_addr[axil_pkg::ADDR_ENTRY_LSB +: ENTRY_AW];
      req_slice <= acc_slice;
      // Truncated to the slice width
      req_wdata <= wdata[sram_geom_pkg::SLICE_LO_W-1:0];
    end
    if (done) begin
      rdata <= bad ? '0 : rsp_data;
      resp  <= bad ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  assign req    = (state == ST_REQ);
  assign req_we = is_wr;

  assign bvalid = (state == ST_RESP) && is_wr;
  assign rvalid = (state == ST_RESP) && !is_wr;
  assign bresp  = resp;
  assign rresp  = resp;

  // Payload must hold while waiting for the arbiter
  a_req_stable: assert property (@(posedge CLK) disable iff (rst)
    req && !gnt |=> req && $stable(req_entry) && $stable(req_slice) && $stable(req_wdata));

endmodule

// ==== source/fpga_ram.sv ====
// --------------------
// Single-port RAM, registered read
// Read returns old data on a write cycle
// --------------------
`timescale 1ns/100ps

module fpga_ram #(
  parameter int WIDTH = 48,
  parameter int ADDR_W = 6
) (
  input  logic              CLK,
  input  logic [ADDR_W-1:0] addr,
  input  logic [WIDTH-1:0]  din,
  input  logic              we,
  output logic [WIDTH-1:0]  dout
);

  // Storage, no initial contents
  logic [WIDTH-1:0] mem [2**ADDR_W];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
    // Read every cycle, dout follows last cycle's address
    dout <= mem[addr];
  end

endmodule

// ==== source/ram_arbiter.sv ====
// --------------------
// Round-robin arbiter for two ports
// One array access per cycle, response one cycle later
// --------------------
`timescale 1ns/100ps

module ram_arbiter #(
  parameter int ENTRY_AW = 6
) (
  input  logic                                 CLK,
  input  logic                                 rst,
  input  logic                                 req0,
  input  logic                                 req_we0,
  input  logic [ENTRY_AW-1:0]                  req_entry0,
  input  logic [sram_geom_pkg::SLICE_IW-1:0]   req_slice0,
  input  logic [sram_geom_pkg::SLICE_LO_W-1:0] req_wdata0,
  input  logic                                 req1,
  input  logic                                 req_we1,
  input  logic [ENTRY_AW-1:0]                  req_entry1,
  input  logic [sram_geom_pkg::SLICE_IW-1:0]   req_slice1,
  input  logic [sram_geom_pkg::SLICE_LO_W-1:0] req_wdata1,
  output logic                                 gnt0,
  output logic                                 gnt1,
  output logic                                 rsp_valid0,
  output logic                                 rsp_valid1,
  output logic [axil_pkg::AXIL_DW-1:0]         rsp_data,
  output logic [ENTRY_AW-1:0]                  A,
  output logic                                 CEN,
  output logic [sram_geom_pkg::ENTRY_W-1:0]    D,
  output logic                                 GWEN,
  output logic [sram_geom_pkg::ENTRY_W-1:0]    WEN,
  input  logic [sram_geom_pkg::ENTRY_W-1:0]    Q
);

  localparam int LO_W = sram_geom_pkg::SLICE_LO_W;
  localparam int HI_W = sram_geom_pkg::SLICE_HI_W;

  logic                              ptr;
  logic                              any;
  logic                              sel;
  logic                              sel_we;
  logic [sram_geom_pkg::SLICE_IW-1:0] sel_slice;
  logic [LO_W-1:0]                   sel_wdata;
  logic                              rsp_pend;
  logic                              rsp_port;
  logic [sram_geom_pkg::SLICE_IW-1:0] rsp_slice;

  // ptr low favors port 0 on a tie
  assign gnt0 = req0 && (!req1 || !ptr);
  assign gnt1 = req1 && (!req0 || ptr);
  assign any  = gnt0 || gnt1;
  assign sel  = gnt1;

  assign sel_we    = sel ? req_we1 : req_we0;
  assign sel_slice = sel ? req_slice1 : req_slice0;
  assign sel_wdata = sel ? req_wdata1 : req_wdata0;

  // Array controls, active low
  assign A    = sel ? req_entry1 : req_entry0;
  assign CEN  = !any;
  assign GWEN = !(any && sel_we);

  // Winner's data into its slice lane
  always_comb begin
    D   = '0;
    WEN = '1;
    case (sel_slice)
      2'd0: begin
        D[0 +: LO_W]   = sel_wdata;
        WEN[0 +: LO_W] = '0;
      end
      2'd1: begin
        D[LO_W +: LO_W]   = sel_wdata;
        WEN[LO_W +: LO_W] = '0;
      end
      2'd2: begin
        D[2*LO_W +: HI_W]   = sel_wdata[HI_W-1:0];
        WEN[2*LO_W +: HI_W] = '0;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      ptr      <= 1'b0;
      rsp_pend <= 1'b0;
    end else begin
      rsp_pend <= any;
      // Pointer moves past the winner
      if (any) begin
        ptr <= !sel;
      end
    end
  end

  // Who gets Q in the next cycle
  always_ff @(posedge CLK) begin
    if (any) begin
      rsp_port  <= sel;
      rsp_slice <= sel_slice;
    end
  end

  assign rsp_valid0 = rsp_pend && !rsp_port;
  assign rsp_valid1 = rsp_pend && rsp_port;

  // Selected slice, zero extended to the bus width
  always_comb begin
    rsp_data = '0;
    case (rsp_slice)
      2'd0:    rsp_data[LO_W-1:0] = Q[0 +: LO_W];
      2'd1:    rsp_data[LO_W-1:0] = Q[LO_W +: LO_W];
      2'd2:    rsp_data[HI_W-1:0] = Q[2*LO_W +: HI_W];
      default: rsp_data = '0;
    endcase
  end

  a_gnt_onehot: assert property (@(posedge CLK) disable iff (rst) !(gnt0 && gnt1));

  a_gnt_req: assert property (@(posedge CLK) disable iff (rst)
    (gnt0 |-> req0) and (gnt1 |-> req1));

endmodule

// ==== source/shared_slice_ram_top.sv ====
// --------------------
// Two AXI4-Lite hosts sharing one 64 x 98 array
// One outstanding transaction per host
// --------------------
`timescale 1ns/100ps

module shared_slice_ram_top #(
  parameter int ENTRY_AW = sram_geom_pkg::ENTRY_AW
) (
  input  logic                           CLK,
  input  logic                           rst,
  input  logic                           h0_awvalid,
  output logic                           h0_awready,
  input  logic [axil_pkg::AXIL_AW-1:0]   h0_awaddr,
  input  logic                           h0_wvalid,
  output logic                           h0_wready,
  input  logic [axil_pkg::AXIL_DW-1:0]   h0_wdata,
  input  logic [axil_pkg::AXIL_DW/8-1:0] h0_wstrb,
  output logic                           h0_bvalid,
  input  logic                           h0_bready,
  output logic [1:0]                     h0_bresp,
  input  logic                           h0_arvalid,
  output logic                           h0_arready,
  input  logic [axil_pkg::AXIL_AW-1:0]   h0_araddr,
  output logic                           h0_rvalid,
  input  logic                           h0_rready,
  output logic [axil_pkg::AXIL_DW-1:0]   h0_rdata,
  output logic [1:0]                     h0_rresp,
  input  logic                           h1_awvalid,
  output logic                           h1_awready,
  input  logic [axil_pkg::AXIL_AW-1:0]   h1_awaddr,
  input  logic                           h1_wvalid,
  output logic                           h1_wready,
  input  logic [axil_pkg::AXIL_DW-1:0]   h1_wdata,
  input  logic [axil_pkg::AXIL_DW/8-1:0] h1_wstrb,
  output logic                           h1_bvalid,
  input  logic                           h1_bready,
  output logic [1:0]                     h1_bresp,
  input  logic                           h1_arvalid,
  output logic                           h1_arready,
  input  logic [axil_pkg::AXIL_AW-1:0]   h1_araddr,
  output logic                           h1_rvalid,
  input  logic                           h1_rready,
  output logic [axil_pkg::AXIL_DW-1:0]   h1_rdata,
  output logic [1:0]                     h1_rresp
);

  // Port 0 request side
  logic                                 p0_req;
  logic                                 p0_req_we;
  logic [ENTRY_AW-1:0]                  p0_req_entry;
  logic [sram_geom_pkg::SLICE_IW-1:0]   p0_req_slice;
  logic [sram_geom_pkg::SLICE_LO_W-1:0] p0_req_wdata;
  logic                                 p0_gnt;
  logic                                 p0_rsp_valid;

  // Port 1 request side
  logic                                 p1_req;
  logic                                 p1_req_we;
  logic [ENTRY_AW-1:0]                  p1_req_entry;
  logic [sram_geom_pkg::SLICE_IW-1:0]   p1_req_slice;
  logic [sram_geom_pkg::SLICE_LO_W-1:0] p1_req_wdata;
  logic                                 p1_gnt;
  logic                                 p1_rsp_valid;

  // Shared read return
  logic [axil_pkg::AXIL_DW-1:0]         rsp_data;

  // Array pins
  logic [ENTRY_AW-1:0]                  mem_a;
  logic                                 mem_cen;
  logic [sram_geom_pkg::ENTRY_W-1:0]    mem_d;
  logic                                 mem_gwen;
  logic [sram_geom_pkg::ENTRY_W-1:0]    mem_wen;
  logic [sram_geom_pkg::ENTRY_W-1:0]    mem_q;

  axil_slice_port #(.ENTRY_AW(ENTRY_AW)) port0 (
    .CLK       (CLK),
    .rst       (rst),
    .awvalid   (h0_awvalid),
    .awready   (h0_awready),
    .awaddr    (h0_awaddr),
    .wvalid    (h0_wvalid),
    .wready    (h0_wready),
    .wdata     (h0_wdata),
    .wstrb     (h0_wstrb),
    .bvalid    (h0_bvalid),
    .bready    (h0_bready),
    .bresp     (h0_bresp),
    .arvalid   (h0_arvalid),
    .arready   (h0_arready),
    .araddr    (h0_araddr),
    .rvalid    (h0_rvalid),
    .rready    (h0_rready),
    .rdata     (h0_rdata),
    .rresp     (h0_rresp),
    .req       (p0_req),
    .req_we    (p0_req_we),
    .req_entry (p0_req_entry),
    .req_slice (p0_req_slice),
    .req_wdata (p0_req_wdata),
    .gnt       (p0_gnt),
    .rsp_valid (p0_rsp_valid),
    .rsp_data  (rsp_data)
  );

  axil_slice_port #(.ENTRY_AW(ENTRY_AW)) port1 (
    .CLK       (CLK),
    .rst       (rst),
    .awvalid   (h1_awvalid),
    .awready   (h1_awready),
    .awaddr    (h1_awaddr),
    .wvalid    (h1_wvalid),
    .wready    (h1_wready),
    .wdata     (h1_wdata),
    .wstrb     (h1_wstrb),
    .bvalid    (h1_bvalid),
    .bready    (h1_bready),
    .bresp     (h1_bresp),
    .arvalid   (h1_arvalid),
    .arready   (h1_arready),
    .araddr    (h1_araddr),
    .rvalid    (h1_rvalid),
    .rready    (h1_rready),
    .rdata     (h1_rdata),
    .rresp     (h1_rresp),
    .req       (p1_req),
    .req_we    (p1_req_we),
    .req_entry (p1_req_entry),
    .req_slice (p1_req_slice),
    .req_wdata (p1_req_wdata),
    .gnt       (p1_gnt),
    .rsp_valid (p1_rsp_valid),
    .rsp_data  (rsp_data)
  );

  ram_arbiter #(.ENTRY_AW(ENTRY_AW)) arb0 (
    .CLK        (CLK),
    .rst        (rst),
    .req0       (p0_req),
    .req_we0    (p0_req_we),
    .req_entry0 (p0_req_entry),
    .req_slice0 (p0_req_slice),
    .req_wdata0 (p0_req_wdata),
    .req1       (p1_req),
    .req_we1    (p1_req_we),
    .req_entry1 (p1_req_entry),
    .req_slice1 (p1_req_slice),
    .req_wdata1 (p1_req_wdata),
    .gnt0       (p0_gnt),
    .gnt1       (p1_gnt),
    .rsp_valid0 (p0_rsp_valid),
    .rsp_valid1 (p1_rsp_valid),
    .rsp_data   (rsp_data),
    .A          (mem_a),
    .CEN        (mem_cen),
    .D          (mem_d),
    .GWEN       (mem_gwen),
    .WEN        (mem_wen),
    .Q          (mem_q)
  );

  spsram_64x98 #(.ENTRY_AW(ENTRY_AW)) mem0 (
    .CLK  (CLK),
    .A    (mem_a),
    .CEN  (mem_cen),
    .D    (mem_d),
    .GWEN (mem_gwen),
    .WEN  (mem_wen),
    .Q    (mem_q)
  );

endmodule

// ==== source/spsram_64x98.sv ====
// --------------------
// 98-bit array wrapper, controls active low
// Only the top WEN bit of each slice counts
// Q holds while CEN is high
// --------------------
`timescale 1ns/100ps

module spsram_64x98 #(
  parameter int ENTRY_AW = 6
) (
  input  logic                              CLK,
  input  logic [ENTRY_AW-1:0]               A,
  input  logic                              CEN,
  input  logic [sram_geom_pkg::ENTRY_W-1:0] D,
  input  logic                              GWEN,
  input  logic [sram_geom_pkg::ENTRY_W-1:0] WEN,
  output logic [sram_geom_pkg::ENTRY_W-1:0] Q
);

  localparam int LO_W = sram_geom_pkg::SLICE_LO_W;
  localparam int HI_W = sram_geom_pkg::SLICE_HI_W;

  logic [ENTRY_AW-1:0] addr_hold;
  logic [ENTRY_AW-1:0] addr;
  logic                ram0_we;
  logic                ram1_we;
  logic                ram2_we;

  // Slice write enables from top WEN bit of each slice
  assign ram0_we = !CEN && !GWEN && !WEN[LO_W-1];
  assign ram1_we = !CEN && !GWEN && !WEN[2*LO_W-1];
  assign ram2_we = !CEN && !GWEN && !WEN[2*LO_W+HI_W-1];

  // Last enabled address kept while deselected
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      addr_hold <= A;
    end
  end

  assign addr = CEN ? addr_hold : A;

  fpga_ram #(.WIDTH(LO_W), .ADDR_W(ENTRY_AW)) ram0 (
    .CLK  (CLK),
    .addr (addr),
    .din  (D[0 +: LO_W]),
    .we   (ram0_we),
    .dout (Q[0 +: LO_W])
  );

  fpga_ram #(.WIDTH(LO_W), .ADDR_W(ENTRY_AW)) ram1 (
    .CLK  (CLK),
    .addr (addr),
    .din  (D[LO_W +: LO_W]),
    .we   (ram1_we),
    .dout (Q[LO_W +: LO_W])
  );

  fpga_ram #(.WIDTH(HI_W), .ADDR_W(ENTRY_AW)) ram2 (
    .CLK  (CLK),
    .addr (addr),
    .din  (D[2*LO_W +: HI_W]),
    .we   (ram2_we),
    .dout (Q[2*LO_W +: HI_W])
  );

  // Write only on a selected cycle
  a_gwen_cen: assert property (@(posedge CLK) !(CEN && !GWEN));

endmodule

// ==== source/sram_geom_pkg.sv ====
// --------------------
// Geometry of the shared 64 x 98 array
// Entry split into slices of 48, 48 and 2 bits
// --------------------
package sram_geom_pkg;

  // Full entry width
  localparam int ENTRY_W = 98;

  // Slices 0 and 1
  localparam int SLICE_LO_W = 48;

  // Slice 2, the two top bits
  localparam int SLICE_HI_W = 2;

  // Entries in the array
  localparam int DEPTH = 64;

  // Entry address width
  localparam int ENTRY_AW = 6;

  // Valid slice indices 0 to 2
  localparam int SLICE_CNT = 3;
  localparam int SLICE_IW = 2;

endpackage
